// File: Makefile
# Verilator build and run of the datapath testbench

LOG = sim.log

.PHONY: compile run clean

compile:
	verilator --binary --assert -f nx_datapath.f --top-module nx_datapath_tb -Mdir obj_dir -o sim

run: compile
	./obj_dir/sim > $(LOG) 2>&1; cat $(LOG)
	grep -qx '\*\* PASS \*\*' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: nx_datapath.f
verilog/nx_pkg.sv
verilog/nx_alu.sv
verilog/nx_addr_unit.sv
verilog/nx_acc_unit.sv
verilog/nx_datapath.sv
verif/nx_datapath_props.sv
verif/nx_datapath_tb.sv

// File: verif/nx_datapath_props.sv
/*
 * Register update properties for the datapath
 * PC step, SP step and flag hold rules, bound into the top level
 */
`timescale 1ns/1ns

module nx_datapath_props (
    input logic            clk,
    input logic            reset,
    input nx_pkg::ctrl_t   ctrl,
    input nx_pkg::flags_t  flags,
    input nx_pkg::status_t status
);
    import nx_pkg::*;

    // ----------------------------------------
    // PC and SP
    // ----------------------------------------
    pc_step: assert property (@(posedge clk) disable iff (reset)
        ctrl.pc_inc && !ctrl.pc_load |=> status.pc == addr_t'($past(status.pc) + 16'd1))
        else $error("PC did not step by one on pc_inc");

    pc_hold: assert property (@(posedge clk) disable iff (reset)
        !ctrl.pc_inc && !ctrl.pc_load |=> $stable(status.pc))
        else $error("PC moved without pc_inc or pc_load");

    sp_down: assert property (@(posedge clk) disable iff (reset)
        ctrl.sp_dec |=> status.sp == addr_t'($past(status.sp) - 16'd1))   // Wins over sp_inc
        else $error("SP did not step down on sp_dec");

    sp_up: assert property (@(posedge clk) disable iff (reset)
        ctrl.sp_inc && !ctrl.sp_dec |=> status.sp == addr_t'($past(status.sp) + 16'd1))
        else $error("SP did not step up on sp_inc");

    sp_hold: assert property (@(posedge clk) disable iff (reset)
        !ctrl.sp_inc && !ctrl.sp_dec |=> $stable(status.sp))
        else $error("SP moved without sp_inc or sp_dec");

    // Flags keep their value unless loaded
    nz_hold: assert property (@(posedge clk) disable iff (reset)
        !ctrl.nz_load |=> $stable(flags.n) && $stable(flags.z))
        else $error("N or Z changed without nz_load");

    c_hold: assert property (@(posedge clk) disable iff (reset)
        !ctrl.c_load |=> $stable(flags.c))
        else $error("C changed without c_load");

endmodule

// File: verif/nx_datapath_tb.sv
/*
 * Testbench for the accumulator datapath
 * Plays control unit and memory, keeps a register model,
 * and compares the DUT view one cycle after each control word
 */
`timescale 1ns/1ns

module nx_datapath_tb;
    import nx_pkg::*;

    localparam addr_t SP_INIT    = 16'h01A0;  // Not the RTL default
    localparam int    MAX_CYCLES = 2000;      // Twice a 1000-cycle bound on the sequence

    // Expected register view after one control word
    typedef struct packed {
        status_t st;
        data_t   ri;
        flags_t  fl;
    } view_t;

    logic    clk = 1'b0;
    logic    reset;
    ctrl_t   ctrl;
    data_t   mem_data_in;
    addr_t   mem_addr;
    data_t   mem_data_out;
    data_t   ri;
    flags_t  flags;
    status_t status;

    data_t   mem [0:65535];        // 64 KiB memory model
    integer  seed = 74;
    int      cycles = 0;
    int      tests = 0;
    int      checks = 0;
    int      errors = 0;
    int      errs_before = 0;
    view_t   m;                    // Model of the registers
    addr_t   m_rem;
    addr_t   m_rdm;
    view_t   exp_q [$];            // Words in flight
    view_t   held;
    logic    armed = 1'b0;
    ctrl_t   w;
    data_t   v;
    addr_t   ea;
    alu_op_e op;
    data_t   wd_exp [4];           // AC, X, PC low, PC high

    always #2 clk = ~clk;                 // 4 ns period
    assign mem_data_in = mem[mem_addr];   // Combinational read

    nx_datapath #(
        .SP_INIT(SP_INIT)
    ) i_dut (
        .clk(clk), .reset(reset), .ctrl(ctrl), .mem_data_in(mem_data_in),
        .mem_addr(mem_addr), .mem_data_out(mem_data_out), .ri(ri),
        .flags(flags), .status(status)
    );

    bind nx_datapath nx_datapath_props u_props (
        .clk(clk), .reset(reset), .ctrl(ctrl), .flags(flags), .status(status)
    );

    // ----------------------------------------
    // Reference and helpers
    // ----------------------------------------
    function automatic data_t rand_byte();
        return data_t'($random(seed));
    endfunction

    function automatic flags_t nz_of(input data_t r, input logic c);
        return {r[7], r == 8'h00, c};   // N from sign and Z from zero
    endfunction

    // Expected ALU result and the flags that nz_load and c_load would give
    function automatic data_t alu_ref(input alu_op_e f, input data_t a, input data_t b,
                                      input logic cin, output flags_t fl);
        logic [8:0] r;
        case (f)
            OP_ADD:  r = {1'b0, a} + {1'b0, b};
            OP_ADC:  r = {1'b0, a} + {1'b0, b} + {8'h00, cin};
            OP_SUB:  r = {a >= b, a - b};       // Carry set when no borrow
            OP_AND:  r = {1'b0, a & b};
            OP_OR:   r = {1'b0, a | b};
            OP_XOR:  r = {1'b0, a ^ b};
            OP_NOT:  r = {1'b0, ~a};
            OP_SHL:  r = {a, 1'b0};             // Old bit 7 into carry
            OP_SHR:  r = {a[0], 1'b0, a[7:1]};
            default: r = {1'b0, b};             // Pass B
        endcase
        fl = nz_of(r[7:0], r[8]);
        return r[7:0];
    endfunction

    task automatic check_val(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
        checks++;
        assert (got === exp)
        else begin
            $display("ERROR %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    // Drive one word whose end state the model already holds
    task automatic issue(input ctrl_t c);
        @(posedge clk);
        ctrl <= c;
        exp_q.push_back(m);
    endtask

    task automatic load_ac_mem(input data_t b);
        w = '0;
        w.ac_load = 1'b1;
        w.ac_sel = AC_MEM;
        m.st.ac = b;
        issue(w);
        mem[m_rem] <= b;   // Seen by the DUT at the next edge
    endtask

    task automatic end_test(input string name);
        issue('0);
        while (exp_q.size() != 0)
            @(posedge clk);
        repeat (2) @(posedge clk);   // Last record compared
        $display("test %s done, %0d errors", name, errors - errs_before);
        errs_before = errors;
        tests++;
    endtask

    // ----------------------------------------
    // Compare one cycle behind the stimulus
    // ----------------------------------------
    always @(negedge clk) begin
        if (armed) begin
            check_val("pc", status.pc, held.st.pc);
            check_val("sp", status.sp, held.st.sp);
            check_val("ac", 16'(status.ac), 16'(held.st.ac));
            check_val("x", 16'(status.x), 16'(held.st.x));
            check_val("ri", 16'(ri), 16'(held.ri));
            check_val("flags", 16'(flags), 16'(held.fl));
        end
        armed = (exp_q.size() != 0);
        if (armed)
            held = exp_q.pop_front();
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("Timeout, the run did not finish within %0d cycles", MAX_CYCLES);
            $display("** FAIL **");
            $finish;
        end
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    initial begin
        reset <= 1'b1;
        ctrl  <= '0;
        for (int i = 0; i < 65536; i++)
            mem[i] <= rand_byte();
        m = '0;
        m.st.sp = SP_INIT;
        m_rem = '0;
        m_rdm = '0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        end_test("reset");

        // Fetch loads REM from PC, RDM low from memory, then RI with PC + 1
        w = '0;
        w.rem_load = 1'b1;
        w.addr_sel = SEL_PC;
        m_rem = m.st.pc;
        issue(w);
        w = '0;
        w.rdm_load_lo = 1'b1;
        m_rdm[7:0] = mem[m_rem];
        issue(w);
        w = '0;
        w.ri_load = 1'b1;
        w.pc_inc = 1'b1;
        m.ri = m_rdm[7:0];
        m.st.pc = m.st.pc + 16'd1;
        issue(w);
        for (int k = 0; k < 2; k++) begin   // Jump target low byte then high byte
            w = '0;
            w.rem_load = 1'b1;
            w.addr_sel = SEL_PC;
            m_rem = m.st.pc;
            issue(w);
            w = '0;
            w.rdm_load_lo = (k == 0);
            w.rdm_load_hi = (k == 1);
            w.pc_inc = 1'b1;
            m_rdm[8*k +: 8] = mem[m_rem];
            m.st.pc = m.st.pc + 16'd1;
            issue(w);
        end
        w = '0;
        w.pc_load = 1'b1;
        w.pc_inc = 1'b1;   // Load wins
        m.st.pc = m_rdm;
        issue(w);
        end_test("fetch");

        for (int k = 0; k < 200; k++) begin
            op = alu_op_e'(4'($unsigned($random(seed)) % 10));
            v = rand_byte();
            w = '0;
            w.alu_op = op;
            w.alu_b_one = 1'($random(seed));
            w.ac_load = 1'b1;
            w.nz_load = 1'b1;
            w.c_load = 1'b1;
            m.st.ac = alu_ref(op, m.st.ac, w.alu_b_one ? 8'h01 : v, m.fl.c, m.fl);
            issue(w);
            mem[m_rem] <= v;   // Operand at REM
        end
        end_test("alu");

        // X by load, by increment, then load over increment
        for (int k = 0; k < 3; k++) begin
            v = rand_byte();
            w = '0;
            w.x_load = (k != 1);
            w.x_inc = (k != 0);
            m.st.x = (k == 1) ? m.st.x + 8'd1 : v;
            issue(w);
            mem[m_rem] <= v;
        end
        for (int k = 0; k < 2; k++) begin
            v = (k == 1) ? 8'hFF : rand_byte();   // High byte FF so REM + X can wrap
            w = '0;
            w.rdm_load_lo = (k == 0);
            w.rdm_load_hi = (k == 1);
            m_rdm[8*k +: 8] = v;
            issue(w);
            mem[m_rem] <= v;
        end
        w = '0;
        w.rem_load = 1'b1;
        w.addr_sel = SEL_RDM;
        m_rem = m_rdm;
        issue(w);
        ea = m_rem + {8'h00, m.st.x};
        w = '0;
        w.indexed = 1'b1;
        w.ac_load = 1'b1;
        w.ac_sel = AC_MEM;
        w.nz_load = 1'b1;
        m.st.ac = mem[ea];
        m.fl = nz_of(mem[ea], m.fl.c);
        issue(w);
        @(negedge clk);
        check_val("mem_addr", mem_addr, ea);
        end_test("indexed");

        w = '0;
        w.sp_dec = 1'b1;
        w.sp_inc = 1'b1;   // Decrement wins
        m.st.sp = m.st.sp - 16'd1;
        issue(w);
        w = '0;
        w.rem_load = 1'b1;
        w.addr_sel = SEL_SP;
        m_rem = m.st.sp;
        issue(w);
        wd_exp[0] = m.st.ac;
        wd_exp[1] = m.st.x;
        wd_exp[2] = m.st.pc[7:0];
        wd_exp[3] = m.st.pc[15:8];
        for (int k = 0; k < 4; k++) begin
            w = '0;
            w.wdata_sel = wdata_sel_e'(2'(k));
            issue(w);
            @(negedge clk);
            check_val("mem_addr", mem_addr, m_rem);
            check_val("mem_data_out", 16'(mem_data_out), 16'(wd_exp[k]));
        end
        w = '0;
        w.sp_inc = 1'b1;
        m.st.sp = m.st.sp + 16'd1;
        issue(w);
        end_test("stack");

        // TAX then TXA with a zero byte and a negative byte
        for (int k = 0; k < 2; k++) begin
            v = (k == 0) ? 8'h00 : 8'h9C;
            load_ac_mem(v);
            w = '0;
            w.x_load = 1'b1;
            w.x_from_ac = 1'b1;
            m.st.x = m.st.ac;
            issue(w);
            mem[m_rem] <= ~v;  // Memory byte differs from AC during TAX
            load_ac_mem(~v);   // AC differs before TXA
            w = '0;
            w.ac_load = 1'b1;
            w.ac_sel = AC_X;
            w.nz_load = 1'b1;
            m.st.ac = m.st.x;
            m.fl = nz_of(m.st.x, m.fl.c);
            issue(w);
        end
        end_test("transfer");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: verilog/nx_acc_unit.sv
/*
 * Accumulator unit
 * Holds AC, the X index register and the NZC flags,
 * with the AC and X input selects
 */
`timescale 1ns/1ns

module nx_acc_unit (
    input  logic           clk,
    input  logic           reset,
    input  nx_pkg::ctrl_t  ctrl,
    input  nx_pkg::data_t  mem_data_in,
    input  nx_pkg::data_t  alu_result,
    input  logic           alu_carry,
    output nx_pkg::data_t  ac,
    output nx_pkg::data_t  x,
    output nx_pkg::flags_t flags
);
    import nx_pkg::*;

    data_t ac_in;   // Also feeds N and Z
    data_t x_in;

    // ----------------------------------------
    // Input selects
    // ----------------------------------------
    always_comb begin
        case (ctrl.ac_sel)
            AC_MEM:  ac_in = mem_data_in;  // Loads and pops
            AC_X:    ac_in = x;            // TXA
            default: ac_in = alu_result;
        endcase
    end

    assign x_in = ctrl.x_from_ac ? ac : mem_data_in;  // TAX or LDX

    // ----------------------------------------
    // Registers
    // ----------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ac <= '0;
        end else if (ctrl.ac_load) begin
            ac <= ac_in;
        end
    end

    // Load has priority over increment
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            x <= '0;
        end else if (ctrl.x_load) begin
            x <= x_in;
        end else if (ctrl.x_inc) begin
            x <= x + data_t'(1);           // INX, wraps at 8 bits
        end
    end

    // N/Z and C load separately, CMP touches only some of them
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            flags <= '0;
        end else begin
            if (ctrl.nz_load) begin
                flags.n <= ac_in[DATA_W-1];  // Sign bit
                flags.z <= (ac_in == '0);
            end
            if (ctrl.c_load)
                flags.c <= alu_carry;
        end
    end

endmodule

// File: verilog/nx_addr_unit.sv
/*
 * Address unit
 * Holds PC, SP, REM, RDM and RI, forms the memory address
 * with optional X indexing and picks the memory write byte
 */
`timescale 1ns/1ns

module nx_addr_unit #(
    parameter nx_pkg::addr_t SP_INIT = 16'h00FF
) (
    input  logic           clk,
    input  logic           reset,
    input  nx_pkg::ctrl_t  ctrl,
    input  nx_pkg::data_t  mem_data_in,
    input  nx_pkg::data_t  ac,
    input  nx_pkg::data_t  x,
    output nx_pkg::addr_t  pc,
    output nx_pkg::addr_t  sp,
    output nx_pkg::data_t  ri,
    output nx_pkg::addr_t  mem_addr,
    output nx_pkg::data_t  mem_data_out
);
    import nx_pkg::*;

    addr_t rem;       // Memory address register
    addr_t rdm;       // Two-byte data register
    addr_t rem_in;    // REM source after addr_sel
    addr_t x_ext;     // X zero-extended to address width

    // ----------------------------------------
    // Program counter and stack pointer
    // ----------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= '0;
        end else if (ctrl.pc_load) begin
            pc <= rdm;                    // Jump target from RDM
        end else if (ctrl.pc_inc) begin
            pc <= pc + addr_t'(1);
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sp <= SP_INIT;
        end else if (ctrl.sp_dec) begin
            sp <= sp - addr_t'(1);        // Push: pre-decrement
        end else if (ctrl.sp_inc) begin
            sp <= sp + addr_t'(1);        // Pop: post-increment
        end
    end

    // ----------------------------------------
    // REM, RDM and RI
    // ----------------------------------------
    always_comb begin
        case (ctrl.addr_sel)
            SEL_PC:  rem_in = pc;
            SEL_SP:  rem_in = sp;
            default: rem_in = rdm;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rem <= '0;
        end else if (ctrl.rem_load) begin
            rem <= rem_in;
        end
    end

    // Low and high bytes fill independently, for 16-bit operand fetch
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rdm <= '0;
        end else begin
            if (ctrl.rdm_load_lo)
                rdm[DATA_W-1:0] <= mem_data_in;
            if (ctrl.rdm_load_hi)
                rdm[ADDR_W-1:DATA_W] <= mem_data_in;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ri <= '0;
        end else if (ctrl.ri_load) begin
            ri <= rdm[DATA_W-1:0];        // Opcode byte
        end
    end

    // ----------------------------------------
    // Memory address and write data
    // ----------------------------------------
    assign x_ext    = {{(ADDR_W-DATA_W){1'b0}}, x};
    assign mem_addr = ctrl.indexed ? rem + x_ext : rem;  // Wraps modulo 2^16

    always_comb begin
        case (ctrl.wdata_sel)
            WD_X:     mem_data_out = x;
            WD_PC_LO: mem_data_out = pc[DATA_W-1:0];
            WD_PC_HI: mem_data_out = pc[ADDR_W-1:DATA_W];
            default:  mem_data_out = ac;
        endcase
    end

endmodule

// File: verilog/nx_alu.sv
/*
 * Combinational ALU with carry
 * Add, add with carry, subtract, logic ops, invert and shifts
 */
`timescale 1ns/1ns

module nx_alu (
    input  nx_pkg::data_t   a,
    input  nx_pkg::data_t   b,
    input  nx_pkg::alu_op_e op,
    input  logic            carry_in,
    output nx_pkg::data_t   result,
    output logic            carry_out
);
    import nx_pkg::*;

    logic [DATA_W:0] sum;   // Extra bit holds the carry
    logic [DATA_W:0] diff;

    assign sum  = {1'b0, a} + {1'b0, b} + ((op == OP_ADC) ? {{DATA_W{1'b0}}, carry_in} : '0);
    assign diff = {1'b0, a} - {1'b0, b};

    always_comb begin
        result    = b;
        carry_out = 1'b0;
        case (op)
            OP_ADD, OP_ADC: begin
                result    = sum[DATA_W-1:0];
                carry_out = sum[DATA_W];
            end
            OP_SUB: begin
                result    = diff[DATA_W-1:0];
                carry_out = ~diff[DATA_W];   // Set when no borrow
            end
            OP_AND: result = a & b;
            OP_OR:  result = a | b;
            OP_XOR: result = a ^ b;
            OP_NOT: result = ~a;
            OP_SHL: begin
                result    = {a[DATA_W-2:0], 1'b0};
                carry_out = a[DATA_W-1];     // Bit shifted out
            end
            OP_SHR: begin
                result    = {1'b0, a[DATA_W-1:1]};
                carry_out = a[0];
            end
            default: begin
                // PASS_B and unused codes
                result    = b;
                carry_out = 1'b0;
            end
        endcase
    end

endmodule

// File: verilog/nx_datapath.sv
/*
 * Datapath top level
 * Wires the address unit, accumulator unit and ALU,
 * and collects the register view for the control unit
 */
`timescale 1ns/1ns

module nx_datapath #(
    parameter nx_pkg::addr_t SP_INIT = 16'h00FF
) (
    input  logic            clk,
    input  logic            reset,
    input  nx_pkg::ctrl_t   ctrl,
    input  nx_pkg::data_t   mem_data_in,
    output nx_pkg::addr_t   mem_addr,
    output nx_pkg::data_t   mem_data_out,
    output nx_pkg::data_t   ri,
    output nx_pkg::flags_t  flags,
    output nx_pkg::status_t status
);
    import nx_pkg::*;

    // ----------------------------------------
    // Internal wires
    // ----------------------------------------
    addr_t pc;
    addr_t sp;
    data_t ac;
    data_t x;
    data_t alu_b;         // Memory byte or constant 1
    data_t alu_result;
    logic  alu_carry;

    assign alu_b = ctrl.alu_b_one ? data_t'(1) : mem_data_in;  // INC/DEC use 1

    nx_addr_unit #(
        .SP_INIT(SP_INIT)
    ) u_addr (
        .clk(clk), .reset(reset), .ctrl(ctrl), .mem_data_in(mem_data_in),
        .ac(ac), .x(x), .pc(pc), .sp(sp), .ri(ri),
        .mem_addr(mem_addr), .mem_data_out(mem_data_out)
    );

    nx_acc_unit u_acc (
        .clk(clk), .reset(reset), .ctrl(ctrl), .mem_data_in(mem_data_in),
        .alu_result(alu_result), .alu_carry(alu_carry),
        .ac(ac), .x(x), .flags(flags)
    );

    nx_alu u_alu (
        .a(ac), .b(alu_b), .op(ctrl.alu_op), .carry_in(flags.c),
        .result(alu_result), .carry_out(alu_carry)
    );

    // Register view
    assign status.pc = pc;
    assign status.sp = sp;
    assign status.ac = ac;
    assign status.x  = x;

endmodule

// File: verilog/nx_pkg.sv
/*
 * Shared definitions for the 8-bit accumulator datapath
 * Data and address widths, select and ALU-operation codes,
 * and the control word, flag and status structures
 */
package nx_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    localparam int DATA_W = 8;   // Data byte
    localparam int ADDR_W = 16;  // 64 KiB address space

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [ADDR_W-1:0] addr_t;

    // ----------------------------------------
    // Select and operation codes
    // ----------------------------------------
    typedef enum logic [1:0] {
        SEL_RDM = 2'b00,  // Operand address fetched into RDM
        SEL_PC  = 2'b01,  // Instruction fetch
        SEL_SP  = 2'b10   // Stack access
    } addr_sel_e;

    typedef enum logic [1:0] {
        WD_AC    = 2'b00,  // STA, PUSH
        WD_X     = 2'b01,  // STX
        WD_PC_LO = 2'b10,  // CALL return address, low byte
        WD_PC_HI = 2'b11   // CALL return address, high byte
    } wdata_sel_e;

    typedef enum logic [1:0] {
        AC_ALU = 2'b00,
        AC_MEM = 2'b01,  // LDA, LDI, POP
        AC_X   = 2'b10   // TXA
    } ac_sel_e;

    typedef enum logic [3:0] {
        OP_PASS_B = 4'h0,
        OP_ADD    = 4'h1,
        OP_ADC    = 4'h2,
        OP_SUB    = 4'h3,
        OP_AND    = 4'h4,
        OP_OR     = 4'h5,
        OP_XOR    = 4'h6,
        OP_NOT    = 4'h7,
        OP_SHL    = 4'h8,
        OP_SHR    = 4'h9
    } alu_op_e;

    // ----------------------------------------
    // Control word, one per cycle
    // ----------------------------------------
    typedef struct packed {
        logic       pc_inc;
        logic       pc_load;      // Wins over pc_inc
        logic       sp_inc;
        logic       sp_dec;       // Wins over sp_inc
        logic       rem_load;
        logic       rdm_load_lo;
        logic       rdm_load_hi;
        logic       ri_load;
        logic       ac_load;
        logic       x_load;       // Wins over x_inc
        logic       x_inc;
        logic       x_from_ac;    // TAX source
        logic       nz_load;
        logic       c_load;
        logic       indexed;      // mem_addr = REM + X
        addr_sel_e  addr_sel;
        wdata_sel_e wdata_sel;
        ac_sel_e    ac_sel;
        alu_op_e    alu_op;
        logic       alu_b_one;    // ALU B is constant 1
    } ctrl_t;

    typedef struct packed {
        logic n;
        logic z;
        logic c;
    } flags_t;

    // Register view for the control unit
    typedef struct packed {
        addr_t pc;
        addr_t sp;
        data_t ac;
        data_t x;
    } status_t;

endpackage
